/* source/f100_bus_pkg.sv */
/*
 * Bus word and address types, plus the default program start address.
 */
package f100_bus_pkg;

  // One data word on the memory bus.
  typedef logic [15:0] word_t;

  // Word address as seen by the CPU.
  typedef logic [15:0] addr_t;

  // Programs start here after reset unless the top level overrides it.
  localparam addr_t RESET_PC = 16'h0100;

endpackage

/* source/f100_isa_pkg.sv */
/*
 * Instruction set definitions: opcodes, instruction fields, condition
 * register bits, ALU result type and sequencer states.
 */
package f100_isa_pkg;

  // ALU operations kept in this core.
  typedef enum logic [3:0] {
    OP_STO = 4'h4,
    OP_LDA = 4'h8,
    OP_ADD = 4'h9,
    OP_SUB = 4'ha,
    OP_CMP = 4'hb,
    OP_AND = 4'hc,
    OP_NEQ = 4'hd,
    OP_JMP = 4'hf
  } opcode_t;

  // Instruction field positions.
  localparam int OP_HI      = 15;
  localparam int OP_LO      = 12;
  localparam int I_LONG     = 11;
  localparam int I_SHORT_HI = 10;
  localparam int I_HALT_LO  = 10;
  localparam int I_PTR_DEC  = 9;
  localparam int I_PTR_UPD  = 8;
  localparam int I_PTR_HI   = 7;

  // Condition register bit positions.
  localparam int CR_C = 4;
  localparam int CR_S = 3;
  localparam int CR_V = 2;
  localparam int CR_Z = 1;

  // Opcode 0 with bits 11:10 at 01 stops the core.
  localparam logic [15:0] HALT_WORD = 16'h0400;

  // Combinational ALU output.
  typedef struct packed {
    logic [16:0] value;
    logic        c;
    logic        s;
    logic        v;
    logic        z;
  } alu_result_t;

  typedef enum logic [3:0] {
    ST_RESET,
    ST_FETCH_0,
    ST_FETCH_1,
    ST_DECODE,
    ST_PTR_0,
    ST_PTR_1,
    ST_UPD_0,
    ST_UPD_1,
    ST_DATA_0,
    ST_DATA_1,
    ST_EXECUTE,
    ST_WRITE_BACK,
    ST_WRITE_BACK_1,
    ST_HALTED,
    ST_FAULT
  } seq_state_t;

endpackage

/* source/f100_mem_if.sv */
/*
 * Single-cycle memory bus between the sequencer and the RAM.
 */
`timescale 1ns/10ps

interface f100_mem_if #(
  parameter int ADDR_WIDTH = 10
);
  import f100_bus_pkg::*;

  logic                  enable;
  logic                  write_enable;
  addr_t                 address;
  word_t                 write_data;
  word_t                 read_data;
  logic [ADDR_WIDTH-1:0] word_index;

  // The RAM decodes only the low address bits.
  assign word_index = address[ADDR_WIDTH-1:0];

  modport core (
    output enable,
    output write_enable,
    output address,
    output write_data,
    input  read_data
  );

  modport ram (
    input  enable,
    input  write_enable,
    input  word_index,
    input  write_data,
    output read_data
  );

endinterface

/* source/f100_alu.sv */
/*
 * Combinational ALU with 17-bit result and C, S, V, Z flags.
 */
`timescale 1ns/10ps

module f100_alu (
  input  f100_isa_pkg::opcode_t     op,
  input  f100_bus_pkg::word_t       accum,
  input  f100_bus_pkg::word_t       operand,
  output f100_isa_pkg::alu_result_t result
);
  import f100_bus_pkg::*;
  import f100_isa_pkg::*;

  logic [16:0] value;
  logic        overflow;

  always_comb
  begin
    value    = {1'b0, operand};
    overflow = 1'b0;
    case (op)
      OP_ADD:
      begin
        value    = {1'b0, operand} + {1'b0, accum};
        // Same-sign inputs giving a result of the other sign.
        overflow = (accum[15] == operand[15]) && (value[15] != accum[15]);
      end
      OP_SUB,
      OP_CMP:
      begin
        // Operand minus accumulator, bit 16 is the borrow.
        value    = {1'b0, operand} - {1'b0, accum};
        overflow = (accum[15] != operand[15]) && (value[15] == accum[15]);
      end
      OP_AND:
      begin
        value = {1'b0, operand & accum};
      end
      OP_NEQ:
      begin
        value = {1'b0, operand ^ accum};
      end
      OP_STO:
      begin
        value = {1'b0, accum};
      end
      OP_LDA,
      OP_JMP:
      begin
        value = {1'b0, operand};
      end
      default:
      begin
        value = {1'b0, operand};
      end
    endcase
  end

  assign result.value = value;
  assign result.c     = value[16];
  assign result.s     = value[15];
  assign result.v     = overflow;
  assign result.z     = (value[15:0] == 16'h0000);

endmodule

/* source/f100_sequencer.sv */
/*
 * Fetch, decode, addressing-mode and write-back FSM.
 * Holds pc, accumulator, condition register and effective address.
 */
`timescale 1ns/10ps

module f100_sequencer #(
  parameter f100_bus_pkg::addr_t START_PC = f100_bus_pkg::RESET_PC
) (
  input  logic                      raw_clk,
  input  logic                      button_reset,
  input  logic                      button_halt,
  f100_mem_if.core                  mem,
  output f100_isa_pkg::opcode_t     alu_op,
  output f100_bus_pkg::word_t       alu_accum,
  output f100_bus_pkg::word_t       alu_operand,
  input  f100_isa_pkg::alu_result_t alu_out,
  output f100_bus_pkg::word_t       accum,
  output f100_bus_pkg::word_t       pc,
  output logic [3:0]                flags,
  output logic                      halted,
  output logic                      fault
);
  import f100_bus_pkg::*;
  import f100_isa_pkg::*;

  seq_state_t       state;
  logic [CR_C:CR_Z] cr;
  word_t            instruction;
  word_t            ea;
  word_t            operand;
  alu_result_t      result;
  logic             ptr_update;
  logic             ptr_mode;
  logic             arith_op;
  word_t            ptr_next;

  assign alu_op      = opcode_t'(instruction[OP_HI:OP_LO]);
  assign alu_accum   = accum;
  assign alu_operand = operand;

  // Pointer forms have bit 11 set and a nonzero P field.
  assign ptr_mode = instruction[I_LONG] && (instruction[I_PTR_HI:0] != 8'h00);
  assign arith_op = (alu_op == OP_ADD) || (alu_op == OP_SUB) || (alu_op == OP_CMP);
  assign ptr_next = instruction[I_PTR_DEC] ? ea - 16'd1 : ea + 16'd1;

  assign flags  = cr;
  assign halted = (state == ST_HALTED);
  assign fault  = (state == ST_FAULT);

  // Bus requests are decoded from the state so the RAM sees them this cycle.
  always_comb
  begin
    mem.enable       = 1'b0;
    mem.write_enable = 1'b0;
    mem.address      = ea;
    mem.write_data   = accum;
    case (state)
      ST_FETCH_0:
      begin
        mem.enable  = 1'b1;
        mem.address = pc;
      end
      ST_PTR_0,
      ST_DATA_0:
      begin
        mem.enable = 1'b1;
      end
      ST_UPD_0:
      begin
        mem.enable       = 1'b1;
        mem.write_enable = 1'b1;
        mem.address      = {8'h00, instruction[I_PTR_HI:0]};
        mem.write_data   = ptr_next;
      end
      ST_WRITE_BACK:
      begin
        if (alu_op == OP_STO)
        begin
          mem.enable       = 1'b1;
          mem.write_enable = 1'b1;
          mem.write_data   = result.value[15:0];
        end
      end
      default:
      begin
        mem.enable = 1'b0;
      end
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state      <= ST_RESET;
      pc         <= START_PC;
      accum      <= '0;
      cr         <= '0;
      ptr_update <= 1'b0;
    end
    else if (!button_halt)
    begin
      state <= ST_HALTED;
    end
    else
    begin
      case (state)
        ST_RESET:
        begin
          state <= ST_FETCH_0;
        end
        ST_FETCH_0:
        begin
          pc    <= pc + 16'd1;
          state <= ST_FETCH_1;
        end
        ST_FETCH_1:
        begin
          instruction <= mem.read_data;
          state       <= ST_DECODE;
        end
        ST_DECODE:
        begin
          ptr_update <= ptr_mode && instruction[I_PTR_UPD];
          if (instruction[OP_HI:I_HALT_LO] == HALT_WORD[OP_HI:I_HALT_LO])
          begin
            state <= ST_HALTED;
          end
          else
          begin
            case (alu_op)
              OP_LDA, OP_STO, OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_NEQ, OP_JMP:
              begin
                if (!instruction[I_LONG])
                begin
                  if (instruction[I_SHORT_HI:0] != 11'd0)
                  begin
                    ea <= {5'd0, instruction[I_SHORT_HI:0]};
                  end
                  else
                  begin
                    // Immediate operand is the next word.
                    ea <= pc;
                    pc <= pc + 16'd1;
                  end
                  state <= ST_DATA_0;
                end
                else
                begin
                  if (ptr_mode)
                  begin
                    ea <= {8'h00, instruction[I_PTR_HI:0]};
                  end
                  else
                  begin
                    // Long mode, address word follows the instruction.
                    ea <= pc;
                    pc <= pc + 16'd1;
                  end
                  state <= ST_PTR_0;
                end
              end
              default:
              begin
                state <= ST_FAULT;
              end
            endcase
          end
        end
        ST_PTR_0:
        begin
          state <= ST_PTR_1;
        end
        ST_PTR_1:
        begin
          ea    <= mem.read_data;
          state <= ptr_update ? ST_UPD_0 : ST_DATA_0;
        end
        ST_UPD_0:
        begin
          // Increment uses the new pointer, decrement the old one.
          if (!instruction[I_PTR_DEC])
          begin
            ea <= ptr_next;
          end
          state <= ST_UPD_1;
        end
        ST_UPD_1:
        begin
          state <= ST_DATA_0;
        end
        ST_DATA_0:
        begin
          state <= ST_DATA_1;
        end
        ST_DATA_1:
        begin
          operand <= mem.read_data;
          state   <= ST_EXECUTE;
        end
        ST_EXECUTE:
        begin
          result <= alu_out;
          state  <= ST_WRITE_BACK;
        end
        ST_WRITE_BACK:
        begin
          cr[CR_C] <= result.c;
          cr[CR_S] <= result.s;
          cr[CR_Z] <= result.z;
          // V is only defined for add and subtract.
          if (arith_op)
          begin
            cr[CR_V] <= result.v;
          end
          state <= ST_FETCH_0;
          case (alu_op)
            OP_LDA, OP_ADD, OP_SUB, OP_AND, OP_NEQ:
            begin
              accum <= result.value[15:0];
            end
            OP_STO:
            begin
              state <= ST_WRITE_BACK_1;
            end
            OP_JMP:
            begin
              pc <= ptr_mode ? result.value[15:0] : ea;
            end
            default:
            begin
              // CMP only touches the flags.
              state <= ST_FETCH_0;
            end
          endcase
        end
        ST_WRITE_BACK_1:
        begin
          state <= ST_FETCH_0;
        end
        ST_HALTED:
        begin
          state <= ST_HALTED;
        end
        default:
        begin
          state <= ST_FAULT;
        end
      endcase
    end
  end

endmodule

/* source/f100_ram.sv */
/*
 * Synchronous word RAM, core port plus a host port for load and readback.
 */
`timescale 1ns/10ps

module f100_ram #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                raw_clk,
  f100_mem_if.ram             mem,
  input  logic                host_enable,
  input  logic                host_write,
  input  f100_bus_pkg::addr_t host_address,
  input  f100_bus_pkg::word_t host_write_data,
  output f100_bus_pkg::word_t host_read_data
);
  import f100_bus_pkg::*;

  word_t                 ram_q [2**ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] host_index;

  assign host_index = host_address[ADDR_WIDTH-1:0];

  // Core requests win, the host gets the idle cycles.
  always_ff @(posedge raw_clk)
  begin
    if (mem.enable)
    begin
      if (mem.write_enable)
      begin
        ram_q[mem.word_index] <= mem.write_data;
      end
      else
      begin
        mem.read_data <= ram_q[mem.word_index];
      end
    end
    else if (host_enable)
    begin
      if (host_write)
      begin
        ram_q[host_index] <= host_write_data;
      end
      else
      begin
        host_read_data <= ram_q[host_index];
      end
    end
  end

endmodule

/* source/f100_top.sv */
/*
 * Top level: sequencer, ALU and RAM with a host load port.
 */
`timescale 1ns/10ps

module f100_top #(
  parameter int                  ADDR_WIDTH = 10,
  parameter f100_bus_pkg::addr_t START_PC   = f100_bus_pkg::RESET_PC
) (
  input  logic                raw_clk,
  input  logic                button_reset,
  input  logic                button_halt,
  input  logic                host_enable,
  input  logic                host_write,
  input  f100_bus_pkg::addr_t host_address,
  input  f100_bus_pkg::word_t host_write_data,
  output f100_bus_pkg::word_t host_read_data,
  output f100_bus_pkg::word_t accum,
  output f100_bus_pkg::word_t pc,
  output logic [3:0]          flags,
  output logic                halted,
  output logic                fault
);
  import f100_bus_pkg::*;
  import f100_isa_pkg::*;

  opcode_t     alu_op;
  word_t       alu_accum;
  word_t       alu_operand;
  alu_result_t alu_out;

  f100_mem_if #(.ADDR_WIDTH(ADDR_WIDTH)) mem_bus ();

  f100_sequencer #(
    .START_PC (START_PC)
  ) sequencer_0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem          (mem_bus.core),
    .alu_op       (alu_op),
    .alu_accum    (alu_accum),
    .alu_operand  (alu_operand),
    .alu_out      (alu_out),
    .accum        (accum),
    .pc           (pc),
    .flags        (flags),
    .halted       (halted),
    .fault        (fault)
  );

  f100_alu alu_0 (
    .op      (alu_op),
    .accum   (alu_accum),
    .operand (alu_operand),
    .result  (alu_out)
  );

  f100_ram #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram_0 (
    .raw_clk         (raw_clk),
    .mem             (mem_bus.ram),
    .host_enable     (host_enable),
    .host_write      (host_write),
    .host_address    (host_address),
    .host_write_data (host_write_data),
    .host_read_data  (host_read_data)
  );

endmodule

/* bench/f100_props.sv */
/*
 * Concurrent assertions on the memory bus and halt state of the sequencer.
 */
`timescale 1ns/10ps

module f100_props (
  input logic raw_clk,
  input logic button_reset,
  input logic mem_enable,
  input logic mem_write_enable,
  input logic halted
);

  // A write is only meaningful as part of a bus request.
  write_needs_enable: assert property (
    @(posedge raw_clk) mem_write_enable |-> mem_enable
  ) else $error("Memory write enable is high while the bus enable is low");

  // Once halted, only a reset brings the core back.
  halt_is_sticky: assert property (
    @(posedge raw_clk) (halted && button_reset) |=> halted
  ) else $error("Halted dropped without a reset");

  // The core stays off the bus in the cycle after reset.
  idle_after_reset: assert property (
    @(posedge raw_clk) !button_reset |=> !mem_enable
  ) else $error("Memory enable is high in the cycle after reset");

endmodule

/* bench/f100_tb.sv */
/*
 * Testbench for f100_top: program table, host port loader, result checks
 * and a cycle timeout.
 */
`timescale 1ns/10ps

module f100_tb;
  import f100_bus_pkg::*;
  import f100_isa_pkg::*;

  localparam int    NUM_ROWS       = 13;
  localparam int    TIMEOUT_CYCLES = NUM_ROWS * 200;
  localparam word_t HALT           = HALT_WORD;

  // One program with its data and the expected end state.
  typedef struct packed {
    logic [0:7][15:0] prog;
    logic [0:1][15:0] data_addr;
    logic [0:1][15:0] data_val;
    logic [15:0]      accum;
    logic [3:0]       flags;
    logic [15:0]      check_addr;
    logic [15:0]      check_val;
    logic             fault;
    logic [15:0]      halt_after;
  } row_t;

  logic  raw_clk;
  logic  button_reset;
  logic  button_halt;
  logic  host_enable;
  logic  host_write;
  addr_t host_address;
  word_t host_write_data;
  word_t host_read_data;
  word_t accum;
  word_t pc;
  logic [3:0] flags;
  logic  halted;
  logic  fault;

  row_t rows [NUM_ROWS];
  int   row_count;
  int   error_count;
  int   check_count;
  int   cycle_count;

  f100_top #(
    .ADDR_WIDTH (10),
    .START_PC   (RESET_PC)
  ) uut (
    .raw_clk         (raw_clk),
    .button_reset    (button_reset),
    .button_halt     (button_halt),
    .host_enable     (host_enable),
    .host_write      (host_write),
    .host_address    (host_address),
    .host_write_data (host_write_data),
    .host_read_data  (host_read_data),
    .accum           (accum),
    .pc              (pc),
    .flags           (flags),
    .halted          (halted),
    .fault           (fault)
  );

  bind f100_sequencer f100_props props_0 (
    .raw_clk          (raw_clk),
    .button_reset     (button_reset),
    .mem_enable       (mem.enable),
    .mem_write_enable (mem.write_enable),
    .halted           (halted)
  );

  initial
  begin
    raw_clk = 1'b0;
  end

  always #50 raw_clk = ~raw_clk;

  always @(posedge raw_clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES)
    begin
      $display("Timeout: the table did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  // Flags are packed as {C, S, V, Z}.
  function automatic logic [3:0] sum_flags(input word_t x, input word_t y);
    int unsigned total;
    int          signed_total;
    total        = int'(x) + int'(y);
    signed_total = int'($signed(x)) + int'($signed(y));
    return {total > 32'hffff, total[15], (signed_total > 32767) || (signed_total < -32768),
            total[15:0] == 16'h0000};
  endfunction

  // Minuend is the memory operand, subtrahend the accumulator.
  function automatic logic [3:0] difference_flags(input word_t m, input word_t s);
    word_t diff;
    int    signed_diff;
    diff        = m - s;
    signed_diff = int'($signed(m)) - int'($signed(s));
    return {m < s, diff[15], (signed_diff > 32767) || (signed_diff < -32768), m == s};
  endfunction

  function automatic logic [3:0] logic_flags(input word_t r);
    return {1'b0, r[15], 1'b0, r == 16'h0000};
  endfunction

  function automatic word_t random_word();
    return 16'($urandom);
  endfunction

  task automatic next_cycle();
    @(posedge raw_clk);
    #1;
  endtask

  task automatic compare(input string name, input int row, input logic [15:0] got,
                         input logic [15:0] expected);
    check_count = check_count + 1;
    if (got !== expected)
    begin
      error_count = error_count + 1;
      $display("ERROR row %0d %s: got 0x%h, expected 0x%h", row, name, got, expected);
    end
  endtask

  task automatic write_word(input addr_t addr, input word_t data);
    host_enable     = 1'b1;
    host_write      = 1'b1;
    host_address    = addr;
    host_write_data = data;
    next_cycle();
  endtask

  task automatic read_word(input addr_t addr, output word_t data);
    host_enable  = 1'b1;
    host_write   = 1'b0;
    host_address = addr;
    next_cycle();
    data        = host_read_data;
    host_enable = 1'b0;
  endtask

  task automatic add_row(input logic [0:7][15:0] prog, input addr_t a0, input word_t v0,
                         input addr_t a1, input word_t v1, input word_t exp_accum,
                         input logic [3:0] exp_flags, input addr_t c_addr, input word_t c_val,
                         input logic exp_fault, input logic [15:0] halt_after);
    row_t r;
    r.prog       = prog;
    r.data_addr  = {a0, a1};
    r.data_val   = {v0, v1};
    r.accum      = exp_accum;
    r.flags      = exp_flags;
    r.check_addr = c_addr;
    r.check_val  = c_val;
    r.fault      = exp_fault;
    r.halt_after = halt_after;
    rows[row_count] = r;
    row_count = row_count + 1;
  endtask

  task automatic build_table();
    word_t a;
    word_t b;
    a = random_word();
    b = random_word();
    // LDA immediate, ADD short.
    add_row({16'h8000, a, 16'h9200, HALT, HALT, HALT, HALT, HALT}, 16'h0200, b, 16'h0201, ~b,
            a + b, sum_flags(a, b), 16'h0200, b, 1'b0, 16'd0);
    // Same program, sum wraps to zero with a carry.
    add_row({16'h8000, 16'h0001, 16'h9200, HALT, HALT, HALT, HALT, HALT}, 16'h0200, 16'hffff,
            16'h0201, 16'h0000, 16'h0000, sum_flags(16'h0001, 16'hffff), 16'h0200, 16'hffff,
            1'b0, 16'd0);
    a = random_word();
    b = random_word();
    // LDA short, SUB short.
    add_row({16'h8200, 16'ha201, HALT, HALT, HALT, HALT, HALT, HALT}, 16'h0200, a, 16'h0201, b,
            b - a, difference_flags(b, a), 16'h0201, b, 1'b0, 16'd0);
    // CMP with a signed overflow, accum keeps its value.
    add_row({16'h8200, 16'hb201, HALT, HALT, HALT, HALT, HALT, HALT}, 16'h0200, 16'h0001,
            16'h0201, 16'h8000, 16'h0001, difference_flags(16'h8000, 16'h0001), 16'h0200,
            16'h0001, 1'b0, 16'd0);
    a = random_word();
    b = random_word();
    // AND and NEQ through long mode.
    add_row({16'h8200, 16'hc800, 16'h0201, HALT, HALT, HALT, HALT, HALT}, 16'h0200, a, 16'h0201,
            b, a & b, logic_flags(a & b), 16'h0201, b, 1'b0, 16'd0);
    add_row({16'h8200, 16'hd800, 16'h0201, HALT, HALT, HALT, HALT, HALT}, 16'h0200, a, 16'h0201,
            b, a ^ b, logic_flags(a ^ b), 16'h0201, b, 1'b0, 16'd0);
    a = random_word();
    // STO pointer-increment via P = 0x10, then load the pointer word back.
    add_row({16'h8000, a, 16'h4910, 16'h8010, HALT, HALT, HALT, HALT}, 16'h0010, 16'h0220,
            16'h0221, ~a, 16'h0221, logic_flags(16'h0221), 16'h0221, a, 1'b0, 16'd0);
    // Same program, pointer word read back through the host port.
    add_row({16'h8000, a, 16'h4910, 16'h8010, HALT, HALT, HALT, HALT}, 16'h0010, 16'h0220,
            16'h0221, ~a, 16'h0221, logic_flags(16'h0221), 16'h0010, 16'h0221, 1'b0, 16'd0);
    // STO pointer-decrement via P = 0x11 stores at the old pointer.
    add_row({16'h8000, a, 16'h4b11, 16'h8011, HALT, HALT, HALT, HALT}, 16'h0011, 16'h0230,
            16'h0230, ~a, 16'h022f, logic_flags(16'h022f), 16'h0230, a, 1'b0, 16'd0);
    // Same program, pointer word read back through the host port.
    add_row({16'h8000, a, 16'h4b11, 16'h8011, HALT, HALT, HALT, HALT}, 16'h0011, 16'h0230,
            16'h0230, ~a, 16'h022f, logic_flags(16'h022f), 16'h0011, 16'h022f, 1'b0, 16'd0);
    a = random_word();
    b = random_word();
    // JMP over an ADD and a halt to a SUB at 0x105.
    add_row({16'h8000, a, 16'hf105, 16'h9200, HALT, 16'ha200, HALT, HALT}, 16'h0200, b,
            16'h0201, ~b, b - a, difference_flags(b, a), 16'h0200, b, 1'b0, 16'd0);
    // Opcode 1 is unused, the LDA after it never runs.
    add_row({16'h8000, a, 16'h1000, 16'h8200, HALT, HALT, HALT, HALT}, 16'h0200, b, 16'h0201,
            ~b, a, logic_flags(a), 16'h0200, b, 1'b1, 16'd0);
    // Endless JMP loop, stopped by the halt button.
    add_row({16'hf100, HALT, HALT, HALT, HALT, HALT, HALT, HALT}, 16'h0200, b, 16'h0201, ~b,
            16'h0000, logic_flags(16'hf100), 16'h0200, b, 1'b0, 16'd20);
  endtask

  task automatic run_row(input int idx);
    row_t        r;
    int          k;
    logic [15:0] waited;
    word_t       got;
    r = rows[idx];
    button_reset = 1'b0;
    button_halt  = 1'b1;
    repeat (4) next_cycle();
    compare("pc in reset", idx, pc, RESET_PC);
    compare("halted in reset", idx, {15'd0, halted}, 16'h0000);
    compare("fault in reset", idx, {15'd0, fault}, 16'h0000);
    for (k = 0; k < 8; k++)
    begin
      write_word(RESET_PC + 16'(k), r.prog[k]);
    end
    write_word(r.data_addr[0], r.data_val[0]);
    write_word(r.data_addr[1], r.data_val[1]);
    host_enable  = 1'b0;
    button_reset = 1'b1;
    waited = 16'd0;
    while (!halted && !fault)
    begin
      next_cycle();
      waited = waited + 16'd1;
      if ((r.halt_after != 16'd0) && (waited == r.halt_after))
      begin
        button_halt = 1'b0;
      end
    end
    compare("accum", idx, accum, r.accum);
    compare("flags", idx, {12'd0, flags}, {12'd0, r.flags});
    compare("fault", idx, {15'd0, fault}, {15'd0, r.fault});
    compare("halted", idx, {15'd0, halted}, {15'd0, ~r.fault});
    read_word(r.check_addr, got);
    compare("ram word", idx, got, r.check_val);
  endtask

  initial
  begin
    int seed;
    int idx;
    button_reset    = 1'b0;
    button_halt     = 1'b1;
    host_enable     = 1'b0;
    host_write      = 1'b0;
    host_address    = '0;
    host_write_data = '0;
    row_count       = 0;
    error_count     = 0;
    check_count     = 0;
    cycle_count     = 0;
    seed = $urandom(32'h4de1_08c7);
    build_table();
    for (idx = 0; idx < row_count; idx++)
    begin
      run_row(idx);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sources.f */
source/f100_bus_pkg.sv
source/f100_isa_pkg.sv
source/f100_mem_if.sv
source/f100_alu.sv
source/f100_sequencer.sv
source/f100_ram.sv
source/f100_top.sv
bench/f100_props.sv
bench/f100_tb.sv

/* Makefile */
SRCS := $(wildcard source/*.sv bench/*.sv)

.PHONY: run clean

run: obj_dir/Vf100_tb
	./obj_dir/Vf100_tb | tee sim.log
	grep -q "^test passed$$" sim.log

obj_dir/Vf100_tb: sources.f $(SRCS)
	verilator --binary --assert --top-module f100_tb -Mdir obj_dir -o Vf100_tb -f sources.f

clean:
	rm -rf obj_dir sim.log
